//--- apb_reg_file.sv
// ----------------------------------------
// APB register file
// decodes transfers into command pulses,
// holds line/enable, muxes read data
// ----------------------------------------
`default_nettype none

module apb_reg_file #(
    parameter int COLS = 80,
    parameter int ROWS = 30
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  video_regs_pkg::reg_addr_t paddr_i,
    input  video_regs_pkg::byte_t pwdata_i,
    output video_regs_pkg::byte_t prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  busy_i,
    input  text_pkg::col_t        cursor_x_i,
    input  text_pkg::row_t        cursor_y_i,
    output logic                  cmd_move_x_o,
    output logic                  cmd_move_y_o,
    output logic                  cmd_write_o,
    output logic                  cmd_scroll_up_o,
    output logic                  cmd_scroll_down_o,
    output logic                  cmd_clear_eol_o,
    output logic                  cmd_clear_screen_o,
    output text_pkg::col_t        cursor_x_req_o,
    output text_pkg::row_t        cursor_y_req_o,
    output video_regs_pkg::byte_t wdata_o,
    output text_pkg::row_t        a_row_o,
    output text_pkg::col_t        a_col_o,
    output logic                  a_we_o,
    input  video_regs_pkg::byte_t a_rdata_i,
    output video_regs_pkg::byte_t a_wdata_o
);
    import video_regs_pkg::*;
    import text_pkg::*;

    logic wr_en;
    logic win_hit;
    logic is_cmd;
    logic busy_eff;
    logic cmd_ok;
    row_t line_q;
    logic tty_en_q;

    assign wr_en   = psel_i && penable_i && pwrite_i;  // end of access phase
    assign win_hit = (paddr_i >= LINE_WINDOW_BASE) && ((paddr_i - LINE_WINDOW_BASE) < COLS);
    assign is_cmd  = paddr_i inside {REG_CURSOR_X, REG_CURSOR_Y, REG_SCROLL_UP,
                                     REG_SCROLL_DOWN, REG_TTY_WRITE, REG_CLEAR_EOL,
                                     REG_CLEAR_SCREEN};

    // a pulse in flight counts as busy too
    assign busy_eff = busy_i || cmd_move_x_o || cmd_move_y_o || cmd_write_o
                      || cmd_clear_eol_o || cmd_clear_screen_o;
    assign cmd_ok    = wr_en && is_cmd && !busy_eff;
    assign pslverr_o = wr_en && is_cmd && busy_eff;  // command dropped
    assign pready_o  = 1'b1;

    // ----------------------------------------
    // command pulses and control registers
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cmd_move_x_o       <= 1'b0;
            cmd_move_y_o       <= 1'b0;
            cmd_write_o        <= 1'b0;
            cmd_scroll_up_o    <= 1'b0;
            cmd_scroll_down_o  <= 1'b0;
            cmd_clear_eol_o    <= 1'b0;
            cmd_clear_screen_o <= 1'b0;
            line_q             <= '0;
            tty_en_q           <= 1'b1;
        end
        else
        begin
            cmd_move_x_o       <= cmd_ok && (paddr_i == REG_CURSOR_X);
            cmd_move_y_o       <= cmd_ok && (paddr_i == REG_CURSOR_Y);
            cmd_write_o        <= cmd_ok && (paddr_i == REG_TTY_WRITE) && tty_en_q;
            cmd_scroll_up_o    <= cmd_ok && (paddr_i == REG_SCROLL_UP);
            cmd_scroll_down_o  <= cmd_ok && (paddr_i == REG_SCROLL_DOWN);
            cmd_clear_eol_o    <= cmd_ok && (paddr_i == REG_CLEAR_EOL);
            cmd_clear_screen_o <= cmd_ok && (paddr_i == REG_CLEAR_SCREEN);
            if (wr_en && (paddr_i == REG_LINE))
                line_q <= row_t'(pwdata_i);
            if (wr_en && (paddr_i == REG_TTY_ENABLE))
                tty_en_q <= pwdata_i[0];
        end
    end

    // held operands, saturated to the screen
    always_ff @(posedge clk_i)
    begin
        if (cmd_ok && (paddr_i == REG_CURSOR_X))
            cursor_x_req_o <= (pwdata_i < COLS) ? col_t'(pwdata_i) : col_t'(COLS - 1);
        if (cmd_ok && (paddr_i == REG_CURSOR_Y))
            cursor_y_req_o <= (pwdata_i < ROWS) ? row_t'(pwdata_i) : row_t'(ROWS - 1);
        if (cmd_ok && (paddr_i == REG_TTY_WRITE))
            wdata_o <= pwdata_i;
    end

    // buffer port A, address valid from setup phase
    assign a_row_o   = line_q;
    assign a_col_o   = col_t'(paddr_i - LINE_WINDOW_BASE);
    assign a_we_o    = wr_en && win_hit;
    assign a_wdata_o = pwdata_i;

    always_comb
    begin
        case (paddr_i)
            REG_LINE:     prdata_o = byte_t'(line_q);
            REG_CURSOR_X: prdata_o = byte_t'(cursor_x_i);
            REG_CURSOR_Y: prdata_o = byte_t'(cursor_y_i);
            REG_TTY_BUSY: prdata_o = byte_t'(busy_i);
            default:      prdata_o = win_hit ? a_rdata_i : '0;
        endcase
    end

    a_one_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({cmd_move_x_o, cmd_move_y_o, cmd_write_o, cmd_scroll_up_o,
                  cmd_scroll_down_o, cmd_clear_eol_o, cmd_clear_screen_o}));

endmodule

`default_nettype wire

//--- char_buffer.sv
// ----------------------------------------
// character buffer
// ROWS x COLS bytes, rows mapped through
// the scroll ring offset
// ----------------------------------------
`default_nettype none

module char_buffer #(
    parameter int COLS = 80,
    parameter int ROWS = 30
) (
    input  logic                  clk_i,
    input  text_pkg::row_t        start_row_i,
    input  text_pkg::row_t        a_row_i,
    input  text_pkg::col_t        a_col_i,
    input  logic                  a_we_i,
    input  video_regs_pkg::byte_t a_wdata_i,
    output video_regs_pkg::byte_t a_rdata_o,
    input  text_pkg::row_t        b_row_i,
    input  text_pkg::col_t        b_col_i,
    input  logic                  b_we_i,
    input  video_regs_pkg::byte_t b_wdata_i
);
    import video_regs_pkg::*;

    localparam int DEPTH = ROWS * COLS;
    localparam int AW    = $clog2(DEPTH);

    byte_t           mem [DEPTH];
    logic   [AW-1:0] addr_a;
    logic   [AW-1:0] addr_b;

    // logical row plus offset, modulo ROWS, then row * COLS + col
    function automatic logic [AW-1:0] cell_addr(input logic [4:0] row,
                                                 input logic [4:0] start,
                                                 input logic [6:0] col);
        int phys;
        phys = (int'(row) + int'(start)) % ROWS;
        return AW'(phys * COLS + int'(col));
    endfunction

    assign addr_a = cell_addr(a_row_i, start_row_i, a_col_i);
    assign addr_b = cell_addr(b_row_i, start_row_i, b_col_i);

    // port B assigned last so it wins a collision
    always_ff @(posedge clk_i)
    begin
        if (a_we_i)
            mem[addr_a] <= a_wdata_i;
        if (b_we_i)
            mem[addr_b] <= b_wdata_i;
        a_rdata_o <= mem[addr_a];  // registered read
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the text terminal testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module text_video_top_tb -f text_video_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtext_video_top_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- text_pkg.sv
// ----------------------------------------
// text screen definitions
// geometry types, control codes and the
// tty engine states
// ----------------------------------------
`default_nettype none

package text_pkg;

    typedef logic [6:0] col_t;  // column index
    typedef logic [4:0] row_t;  // row index

    // ----------------------------------------
    // control characters
    // ----------------------------------------
    localparam logic [7:0] CHAR_CR = 8'h0d;
    localparam logic [7:0] CHAR_LF = 8'h0a;
    localparam logic [7:0] CHAR_BS = 8'h08;

    // tty engine states
    typedef enum logic [3:0] {
        IDLE              = 4'd0,
        WRITE_CHAR        = 4'd1,
        MOVE_X            = 4'd2,
        MOVE_Y            = 4'd3,
        CLEAR_EOL_INIT    = 4'd4,
        CLEAR_EOL_RUN     = 4'd5,  // one cell per cycle
        CLEAR_SCREEN_INIT = 4'd6,
        CLEAR_SCREEN_RUN  = 4'd7   // steps to the next row
    } tty_state_t;

endpackage

`default_nettype wire

//--- text_video_top.f
video_regs_pkg.sv
text_pkg.sv
apb_reg_file.sv
tty_engine.sv
char_buffer.sv
text_video_top.sv
text_video_top_tb.sv

//--- text_video_top.sv
// ----------------------------------------
// text terminal top level
// APB register file, tty engine and
// character buffer
// ----------------------------------------
`default_nettype none

module text_video_top #(
    parameter int COLS = 80,  // at most 80
    parameter int ROWS = 30   // at most 32
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  video_regs_pkg::reg_addr_t paddr_i,
    input  video_regs_pkg::byte_t     pwdata_i,
    output video_regs_pkg::byte_t     prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o
);
    import video_regs_pkg::*;
    import text_pkg::*;

    // ----------------------------------------
    // register file to engine
    // ----------------------------------------
    logic  cmd_move_x;
    logic  cmd_move_y;
    logic  cmd_write;
    logic  cmd_scroll_up;
    logic  cmd_scroll_down;
    logic  cmd_clear_eol;
    logic  cmd_clear_screen;
    col_t  cursor_x_req;
    row_t  cursor_y_req;
    byte_t wdata;
    logic  busy;
    col_t  cursor_x;
    row_t  cursor_y;

    // buffer ports
    row_t  start_row;
    row_t  a_row;
    col_t  a_col;
    logic  a_we;
    byte_t a_wdata;
    byte_t a_rdata;
    row_t  b_row;
    col_t  b_col;
    logic  b_we;
    byte_t b_wdata;

    apb_reg_file #(.COLS(COLS), .ROWS(ROWS)) u_regs (
        .clk_i, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .busy_i(busy), .cursor_x_i(cursor_x), .cursor_y_i(cursor_y),
        .cmd_move_x_o(cmd_move_x), .cmd_move_y_o(cmd_move_y), .cmd_write_o(cmd_write),
        .cmd_scroll_up_o(cmd_scroll_up), .cmd_scroll_down_o(cmd_scroll_down),
        .cmd_clear_eol_o(cmd_clear_eol), .cmd_clear_screen_o(cmd_clear_screen),
        .cursor_x_req_o(cursor_x_req), .cursor_y_req_o(cursor_y_req), .wdata_o(wdata),
        .a_row_o(a_row), .a_col_o(a_col), .a_we_o(a_we),
        .a_rdata_i(a_rdata), .a_wdata_o(a_wdata)
    );

    tty_engine #(.COLS(COLS), .ROWS(ROWS)) u_tty (
        .clk_i, .rst_n_i,
        .cmd_move_x_i(cmd_move_x), .cmd_move_y_i(cmd_move_y), .cmd_write_i(cmd_write),
        .cmd_scroll_up_i(cmd_scroll_up), .cmd_scroll_down_i(cmd_scroll_down),
        .cmd_clear_eol_i(cmd_clear_eol), .cmd_clear_screen_i(cmd_clear_screen),
        .cursor_x_req_i(cursor_x_req), .cursor_y_req_i(cursor_y_req), .wdata_i(wdata),
        .busy_o(busy), .cursor_x_o(cursor_x), .cursor_y_o(cursor_y),
        .start_row_o(start_row), .b_row_o(b_row), .b_col_o(b_col),
        .b_we_o(b_we), .b_wdata_o(b_wdata)
    );

    char_buffer #(.COLS(COLS), .ROWS(ROWS)) u_buf (
        .clk_i, .start_row_i(start_row),
        .a_row_i(a_row), .a_col_i(a_col), .a_we_i(a_we), .a_wdata_i(a_wdata),
        .a_rdata_o(a_rdata),
        .b_row_i(b_row), .b_col_i(b_col), .b_we_i(b_we), .b_wdata_i(b_wdata)
    );

endmodule

`default_nettype wire

//--- text_video_top_tb.sv
// ----------------------------------------
// text terminal testbench
// APB stimulus checked against a screen
// model with cursor and scroll ring
// ----------------------------------------
`default_nettype none

module text_video_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import video_regs_pkg::*;
    import text_pkg::*;

    localparam int COLS        = 80;
    localparam int ROWS        = 30;
    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;     // after the rising edge
    localparam int POLL_LIMIT  = 2000;  // busy reads, a clear-screen takes ~830

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    reg_addr_t paddr;
    byte_t     pwdata;
    byte_t     prdata;
    logic      pready;
    logic      pslverr;

    // screen model, physical rows like the buffer
    byte_t scr [ROWS][COLS];
    int    start;
    int    cx;
    int    cy;
    logic  tty_en;
    int    seed;
    string test_name;

    text_video_top #(.COLS(COLS), .ROWS(ROWS)) dut0 (
        .clk_i(clk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
        .pready_o(pready), .pslverr_o(pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ----------------------------------------
    // failure and compare tasks
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_byte(input string what, input byte_t exp, input byte_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %02h actual %02h", what, exp, act);
            abort_run("wrong byte read back");
        end
    endtask

    task automatic check_col(input string what, input col_t exp, input col_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %0d actual %0d", what, exp, act);
            abort_run("wrong column read back");
        end
    endtask

    task automatic check_row(input string what, input row_t exp, input row_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %0d actual %0d", what, exp, act);
            abort_run("wrong row read back");
        end
    endtask

    task automatic check_err(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error: %s expected pslverr %b actual %b", what, exp, act);
            abort_run("wrong error response");
        end
    endtask

    task automatic check_ready(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error: %s expected pready %b actual %b", what, exp, act);
            abort_run("wrong ready response");
        end
    endtask

    // ----------------------------------------
    // APB transfers, setup then access
    // ----------------------------------------
    task automatic write_reg(input reg_addr_t addr, input byte_t data, output logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);  // mid access phase
        err = pslverr;
        check_ready($sformatf("%s write to %02h", test_name, addr), 1'b1, pready);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output byte_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;  // registered buffer data valid here
        check_ready($sformatf("%s read from %02h", test_name, addr), 1'b1, pready);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_ok(input reg_addr_t addr, input byte_t data);
        logic err;
        write_reg(addr, data, err);
        check_err($sformatf("%s write to %02h", test_name, addr), 1'b0, err);
    endtask

    task automatic wait_idle();
        byte_t b;
        int    n;
        logic  busy;
        n    = 0;
        busy = 1'b1;
        while (busy && (n < POLL_LIMIT))
        begin
            read_reg(REG_TTY_BUSY, b);
            busy = (b[0] !== 1'b0);
            n++;
        end
        if (busy)
        begin
            $display("** Timeout in %s: busy still high after %0d polls", test_name, n);
            abort_run("engine never went idle");
        end
    endtask

    task automatic send_cmd(input reg_addr_t addr, input byte_t data);
        write_ok(addr, data);
        wait_idle();
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic byte_t expected_byte(input int row, input int col);
        return scr[(row + start) % ROWS][col];
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic byte_t random_char();
        case (rand_below(16))
            0:       return CHAR_CR;
            1:       return CHAR_LF;
            2, 3:    return CHAR_BS;
            default: return byte_t'(8'h20 + rand_below(95));  // printable
        endcase
    endfunction

    task automatic erase_to_eol();
        for (int c = cx; c < COLS; c++)
            scr[(cy + start) % ROWS][c] = '0;
    endtask

    task automatic blank_screen();
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++)
                scr[r][c] = '0;
        cx = 0;
        cy = 0;
    endtask

    task automatic new_line();
        if (cy < ROWS - 1)
            cy++;
        else
        begin
            start = (start + 1) % ROWS;  // scroll, bottom line blanked from cx
            erase_to_eol();
        end
    endtask

    task automatic put_char(input byte_t ch);
        if (tty_en)
        begin
            if (ch == CHAR_CR)
                cx = 0;
            else if (ch == CHAR_LF)
                new_line();
            else if (ch == CHAR_BS)
            begin
                if (cx > 0)
                begin
                    cx--;
                    scr[(cy + start) % ROWS][cx] = '0;
                end
            end
            else
            begin
                scr[(cy + start) % ROWS][cx] = ch;
                if (cx < COLS - 1)
                    cx++;
                else
                begin
                    cx = 0;  // wrap
                    new_line();
                end
            end
        end
    endtask

    task automatic type_char(input byte_t ch);
        send_cmd(REG_TTY_WRITE, ch);
        put_char(ch);
    endtask

    // ----------------------------------------
    // read-back against the model
    // ----------------------------------------
    task automatic verify_line(input int row);
        byte_t b;
        write_ok(REG_LINE, byte_t'(row));
        for (int c = 0; c < COLS; c++)
        begin
            read_reg(reg_addr_t'(LINE_WINDOW_BASE + c), b);
            check_byte($sformatf("%s row %0d col %0d", test_name, row, c),
                       expected_byte(row, c), b);
        end
    endtask

    task automatic verify_screen();
        for (int r = 0; r < ROWS; r++)
            verify_line(r);
    endtask

    task automatic verify_cursor();
        byte_t b;
        read_reg(REG_CURSOR_X, b);
        check_col({test_name, " cursor x"}, col_t'(cx), col_t'(b));
        read_reg(REG_CURSOR_Y, b);
        check_row({test_name, " cursor y"}, row_t'(cy), row_t'(b));
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial
    begin
        logic  err;
        byte_t b;
        byte_t v;
        int    r;
        int    c;

        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'h3266;
        start   = 0;
        tty_en  = 1'b1;
        blank_screen();  // engine clears the screen out of reset
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        test_name = "reset";
        wait_idle();
        verify_line(0);
        verify_line(13);
        verify_line(ROWS - 1);
        verify_cursor();

        test_name = "window";
        repeat (24)
        begin
            r = rand_below(ROWS);
            c = rand_below(COLS);
            v = byte_t'($random(seed));
            write_ok(REG_LINE, byte_t'(r));
            write_ok(reg_addr_t'(LINE_WINDOW_BASE + c), v);
            scr[(r + start) % ROWS][c] = v;
            read_reg(REG_LINE, b);
            check_row({test_name, " line"}, row_t'(r), row_t'(b));
            read_reg(reg_addr_t'(LINE_WINDOW_BASE + c), b);
            check_byte($sformatf("%s row %0d col %0d", test_name, r, c), v, b);
        end
        test_name = "cursor";
        cx = rand_below(COLS);
        send_cmd(REG_CURSOR_X, byte_t'(cx));
        cy = rand_below(ROWS);
        send_cmd(REG_CURSOR_Y, byte_t'(cy));
        verify_cursor();

        test_name = "tty";
        cx = 0;
        send_cmd(REG_CURSOR_X, 8'd0);
        type_char(CHAR_BS);  // nothing to erase at column 0
        verify_cursor();
        cx = 76;
        send_cmd(REG_CURSOR_X, byte_t'(cx));
        for (int i = 0; i < 6; i++)
            type_char(byte_t'(8'h41 + i));  // runs past column 79
        repeat (300) type_char(random_char());
        verify_screen();
        verify_cursor();

        test_name = "scroll";
        cy = ROWS - 1;
        send_cmd(REG_CURSOR_Y, byte_t'(cy));
        cx = 10;
        send_cmd(REG_CURSOR_X, byte_t'(cx));
        repeat (3) type_char(CHAR_LF);
        verify_screen();
        verify_cursor();
        send_cmd(REG_SCROLL_UP, 8'd1);
        start = (start + 1) % ROWS;
        verify_screen();
        repeat (2)
        begin
            send_cmd(REG_SCROLL_DOWN, 8'd1);
            start = (start + ROWS - 1) % ROWS;
        end
        verify_screen();

        test_name = "clear";
        write_ok(REG_LINE, 8'd5);
        for (int i = 36; i < 45; i++)
        begin
            write_ok(reg_addr_t'(LINE_WINDOW_BASE + i), 8'h2a);
            scr[(5 + start) % ROWS][i] = 8'h2a;
        end
        cy = 5;
        send_cmd(REG_CURSOR_Y, byte_t'(cy));
        cx = 40;
        send_cmd(REG_CURSOR_X, byte_t'(cx));
        send_cmd(REG_CLEAR_EOL, 8'd1);
        erase_to_eol();
        verify_line(5);
        verify_cursor();
        write_ok(REG_CLEAR_SCREEN, 8'd1);
        write_reg(REG_CURSOR_X, 8'd33, err);  // dropped, engine still clearing
        check_err({test_name, " command while busy"}, 1'b1, err);
        wait_idle();
        blank_screen();
        verify_screen();
        verify_cursor();

        test_name = "enable";
        type_char(8'h41);
        type_char(8'h42);
        write_ok(REG_TTY_ENABLE, 8'd0);
        tty_en = 1'b0;
        repeat (6) type_char(random_char());
        verify_line(0);
        verify_line(1);
        verify_cursor();
        write_ok(REG_TTY_ENABLE, 8'd1);
        tty_en = 1'b1;
        type_char(8'h5a);
        verify_line(0);
        verify_cursor();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- tty_engine.sv
// ----------------------------------------
// tty engine
// cursor, character writes, clears and
// the scroll ring start row
// ----------------------------------------
`default_nettype none

module tty_engine #(
    parameter int COLS = 80,
    parameter int ROWS = 30
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  cmd_move_x_i,
    input  logic                  cmd_move_y_i,
    input  logic                  cmd_write_i,
    input  logic                  cmd_scroll_up_i,
    input  logic                  cmd_scroll_down_i,
    input  logic                  cmd_clear_eol_i,
    input  logic                  cmd_clear_screen_i,
    input  text_pkg::col_t        cursor_x_req_i,
    input  text_pkg::row_t        cursor_y_req_i,
    input  video_regs_pkg::byte_t wdata_i,
    output logic                  busy_o,
    output text_pkg::col_t        cursor_x_o,
    output text_pkg::row_t        cursor_y_o,
    output text_pkg::row_t        start_row_o,
    output text_pkg::row_t        b_row_o,
    output text_pkg::col_t        b_col_o,
    output logic                  b_we_o,
    output video_regs_pkg::byte_t b_wdata_o
);
    import text_pkg::*;

    tty_state_t state_q;
    tty_state_t ret_q;      // where a clear-to-EOL returns
    col_t       cursor_x_q;
    row_t       cursor_y_q;
    col_t       clr_col_q;
    row_t       start_q;
    logic       is_cr;
    logic       is_lf;
    logic       is_bs;
    logic       is_print;
    logic       last_col;
    logic       last_row;
    logic       tty_scroll;

    assign is_cr    = (wdata_i == CHAR_CR);
    assign is_lf    = (wdata_i == CHAR_LF);
    assign is_bs    = (wdata_i == CHAR_BS);
    assign is_print = !(is_cr || is_lf || is_bs);
    assign last_col = (cursor_x_q == col_t'(COLS - 1));
    assign last_row = (cursor_y_q == row_t'(ROWS - 1));

    // LF or wrap on the bottom row
    assign tty_scroll = (state_q == WRITE_CHAR) && last_row
                        && (is_lf || (is_print && last_col));

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q    <= CLEAR_SCREEN_INIT;  // blank screen out of reset
            ret_q      <= IDLE;
            cursor_x_q <= '0;
            cursor_y_q <= '0;
            clr_col_q  <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    ret_q <= IDLE;
                    if (cmd_move_x_i)            state_q <= MOVE_X;
                    else if (cmd_move_y_i)       state_q <= MOVE_Y;
                    else if (cmd_write_i)        state_q <= WRITE_CHAR;
                    else if (cmd_clear_eol_i)    state_q <= CLEAR_EOL_INIT;
                    else if (cmd_clear_screen_i) state_q <= CLEAR_SCREEN_INIT;
                end
                WRITE_CHAR:
                begin
                    state_q <= IDLE;
                    if (is_cr)
                        cursor_x_q <= '0;
                    else if (is_bs)
                    begin
                        if (cursor_x_q != '0)
                            cursor_x_q <= cursor_x_q - 1'b1;
                    end
                    else if (is_print && !last_col)
                        cursor_x_q <= cursor_x_q + 1'b1;
                    else
                    begin
                        // LF, or wrap after the last column
                        if (is_print)
                            cursor_x_q <= '0;
                        if (!last_row)
                            cursor_y_q <= cursor_y_q + 1'b1;
                        else
                            state_q <= CLEAR_EOL_INIT;  // blank new bottom line
                    end
                end
                MOVE_X:
                begin
                    cursor_x_q <= cursor_x_req_i;
                    state_q    <= IDLE;
                end
                MOVE_Y:
                begin
                    cursor_y_q <= cursor_y_req_i;
                    state_q    <= IDLE;
                end
                CLEAR_EOL_INIT:
                begin
                    clr_col_q <= cursor_x_q;
                    state_q   <= CLEAR_EOL_RUN;
                end
                CLEAR_EOL_RUN:
                begin
                    clr_col_q <= clr_col_q + 1'b1;
                    if (clr_col_q == col_t'(COLS - 1))
                        state_q <= ret_q;
                end
                CLEAR_SCREEN_INIT:
                begin
                    cursor_x_q <= '0;
                    cursor_y_q <= '0;
                    ret_q      <= CLEAR_SCREEN_RUN;
                    state_q    <= CLEAR_EOL_INIT;
                end
                CLEAR_SCREEN_RUN:
                begin
                    // cursor_y doubles as the row counter
                    if (last_row)
                    begin
                        cursor_y_q <= '0;
                        state_q    <= IDLE;
                    end
                    else
                    begin
                        cursor_y_q <= cursor_y_q + 1'b1;
                        state_q    <= CLEAR_EOL_INIT;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // scroll ring, wraps at ROWS
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            start_q <= '0;
        else if (tty_scroll || (cmd_scroll_up_i && (state_q == IDLE)))
            start_q <= (start_q == row_t'(ROWS - 1)) ? '0 : start_q + 1'b1;
        else if (cmd_scroll_down_i && (state_q == IDLE))
            start_q <= (start_q == '0) ? row_t'(ROWS - 1) : start_q - 1'b1;
    end

    // ----------------------------------------
    // buffer write port
    // ----------------------------------------
    always_comb
    begin
        b_we_o    = 1'b0;
        b_col_o   = cursor_x_q;
        b_wdata_o = '0;
        case (state_q)
            WRITE_CHAR:
            begin
                if (is_bs)
                begin
                    b_we_o  = (cursor_x_q != '0);  // no-op at column 0
                    b_col_o = cursor_x_q - 1'b1;
                end
                else if (is_print)
                begin
                    b_we_o    = 1'b1;
                    b_wdata_o = wdata_i;
                end
            end
            CLEAR_EOL_RUN:
            begin
                b_we_o  = 1'b1;
                b_col_o = clr_col_q;
            end
            default: b_we_o = 1'b0;
        endcase
    end

    assign b_row_o     = cursor_y_q;
    assign busy_o      = (state_q != IDLE);
    assign cursor_x_o  = cursor_x_q;
    assign cursor_y_o  = cursor_y_q;
    assign start_row_o = start_q;

    a_cursor_x_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cursor_x_q < COLS);
    a_we_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        b_we_o |-> busy_o);

endmodule

`default_nettype wire

//--- video_regs_pkg.sv
// ----------------------------------------
// video register map
// APB offsets and bus-side data types
// ----------------------------------------
`default_nettype none

package video_regs_pkg;

    typedef logic [7:0] byte_t;      // bus and buffer data
    typedef logic [7:0] reg_addr_t;  // APB register offset

    // ----------------------------------------
    // register offsets
    // ----------------------------------------
    localparam reg_addr_t REG_LINE         = 8'h00;  // window line select
    localparam reg_addr_t REG_CURSOR_X     = 8'h01;
    localparam reg_addr_t REG_CURSOR_Y     = 8'h02;
    localparam reg_addr_t REG_SCROLL_UP    = 8'h04;  // strobe
    localparam reg_addr_t REG_SCROLL_DOWN  = 8'h05;  // strobe
    localparam reg_addr_t REG_TTY_WRITE    = 8'h06;
    localparam reg_addr_t REG_TTY_BUSY     = 8'h07;  // read only
    localparam reg_addr_t REG_CLEAR_EOL    = 8'h08;  // strobe
    localparam reg_addr_t REG_CLEAR_SCREEN = 8'h09;  // strobe
    localparam reg_addr_t REG_TTY_ENABLE   = 8'h0a;

    // line data window, one byte per column
    localparam reg_addr_t LINE_WINDOW_BASE = 8'h80;

endpackage

`default_nettype wire
